//--- logic/a2_settings.svh
// ====================
// Widths, raster limits and frame sizes
// shared by the card's video and audio blocks
// ====================

`ifndef A2_SETTINGS_SVH
`define A2_SETTINGS_SVH

// Audio sample widths
`define A2_AUDIO_W   16
`define A2_EXT_W     13
`define A2_SRC10_W   10

// VDP horizontal raster
`define A2_HMAX      856
`define A2_HDIV      4
`define A2_HCNT_W    10

// Framebuffer pixel word, RGB666
`define A2_PIX_W     18

// Apple II frame
`define A2_APPLE_W   560
`define A2_APPLE_H   192

// Super Hi-Res frame
`define A2_VGC_W     640
`define A2_VGC_H     200

`endif

//--- logic/a2_display_pkg.sv
// ====================
// Packed struct types for audio, framebuffer
// streams, frame geometry and colours
// ====================

`default_nettype none

`include "a2_settings.svh"

package a2_display_pkg;

    // Raw audio sources as they arrive from the sound blocks
    typedef struct packed {
        logic [`A2_AUDIO_W-1:0] ens_l;
        logic [`A2_AUDIO_W-1:0] ens_r;
        logic [`A2_SRC10_W-1:0] spr;
        logic [`A2_SRC10_W-1:0] mb_l;
        logic [`A2_SRC10_W-1:0] mb_r;
        logic                   spk;
        logic                   spk_sw;
    } audio_src_t;

    typedef struct packed {
        logic signed [`A2_AUDIO_W-1:0] left;
        logic signed [`A2_AUDIO_W-1:0] right;
    } stereo_t;

    // One scanner output stream
    typedef struct packed {
        logic                 we;
        logic [`A2_PIX_W-1:0] data;
        logic                 vsync;
    } fb_stream_t;

    typedef struct packed {
        logic [10:0] width;
        logic [9:0]  height;
    } fb_geom_t;

    typedef struct packed {
        logic [5:0] r;
        logic [5:0] g;
        logic [5:0] b;
    } rgb666_t;

endpackage

`default_nettype wire

//--- logic/audio_mixer.sv
// ====================
// Two-stage audio mixer: widen the sources,
// then sum them onto the Ensoniq samples
// ====================

`timescale 1ns/1ps
`default_nettype none

`include "a2_settings.svh"

module audio_mixer #(
    parameter bit SPEAKER_ENABLE = 1'b0
) (
    input  logic                    a2bus_if,
    input  logic                    rst_n_i,
    input  a2_display_pkg::audio_src_t src_i,
    output a2_display_pkg::stereo_t    audio_o
);

    localparam int PAD_10 = `A2_EXT_W - `A2_SRC10_W;
    localparam int PAD_EXT = `A2_AUDIO_W - `A2_EXT_W;

    logic                   spk_en;
    logic [`A2_EXT_W-1:0]   spk_ext;
    logic [`A2_EXT_W-1:0]   spr_ext;
    logic [`A2_EXT_W-1:0]   mb_l_ext;
    logic [`A2_EXT_W-1:0]   mb_r_ext;

    // Stage one registers
    logic [`A2_AUDIO_W-1:0] ens_l_q;
    logic [`A2_AUDIO_W-1:0] ens_r_q;
    logic [`A2_EXT_W-1:0]   spk_q;
    logic [`A2_EXT_W-1:0]   spr_q;
    logic [`A2_EXT_W-1:0]   mb_l_q;
    logic [`A2_EXT_W-1:0]   mb_r_q;

    a2_display_pkg::stereo_t audio_q;

    // Speaker counts only when built in or switched on
    assign spk_en = SPEAKER_ENABLE | src_i.spk_sw;
    assign spk_ext = spk_en ? {src_i.spk, {(`A2_EXT_W-1){1'b0}}} : '0;

    // Unsigned sources sit in the top bits of the 13-bit word
    assign spr_ext  = {src_i.spr,  {PAD_10{1'b0}}};
    assign mb_l_ext = {src_i.mb_l, {PAD_10{1'b0}}};
    assign mb_r_ext = {src_i.mb_r, {PAD_10{1'b0}}};

    always_ff @(posedge a2bus_if or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ens_l_q <= '0;
            ens_r_q <= '0;
            spk_q   <= '0;
            spr_q   <= '0;
            mb_l_q  <= '0;
            mb_r_q  <= '0;
        end else begin
            ens_l_q <= src_i.ens_l;
            ens_r_q <= src_i.ens_r;
            spk_q   <= spk_ext;
            spr_q   <= spr_ext;
            mb_l_q  <= mb_l_ext;
            mb_r_q  <= mb_r_ext;
        end
    end

    // Sums wrap at 16 bits
    always_ff @(posedge a2bus_if or negedge rst_n_i) begin
        if (!rst_n_i) begin
            audio_q <= '0;
        end else begin
            audio_q.left  <= ens_l_q + {{PAD_EXT{1'b0}}, spr_q}
                           + {{PAD_EXT{1'b0}}, mb_l_q} + {{PAD_EXT{1'b0}}, spk_q};
            audio_q.right <= ens_r_q + {{PAD_EXT{1'b0}}, spr_q}
                           + {{PAD_EXT{1'b0}}, mb_r_q} + {{PAD_EXT{1'b0}}, spk_q};
        end
    end

    assign audio_o = audio_q;

    // Both stages come out of reset empty
    a_silent_after_reset: assert property (@(posedge a2bus_if) disable iff (!rst_n_i)
        $rose(rst_n_i) |=> audio_o == '0);

endmodule

`default_nettype wire

//--- logic/vdp_raster_counter.sv
// ====================
// VDP horizontal raster counter with a
// divide-by-four prescaler
// ====================

`timescale 1ns/1ps
`default_nettype none

`include "a2_settings.svh"

module vdp_raster_counter (
    input  logic                  a2bus_if,
    input  logic                  rst_n_i,
    input  logic                  hsync_i,
    output logic [`A2_HCNT_W-1:0] cx_o
);

    localparam int CW = `A2_HCNT_W;
    localparam int DW = $clog2(`A2_HDIV);
    localparam logic [CW-1:0] HMAX = CW'(`A2_HMAX);
    localparam logic [DW-1:0] DIV_LAST = DW'(`A2_HDIV - 1);

    logic [DW-1:0] div_q;
    logic [CW-1:0] cx_q;
    logic          step;

    // One raster step per prescaler wrap, held at the maximum
    assign step = (div_q == DIV_LAST) && (cx_q < HMAX);

    always_ff @(posedge a2bus_if or negedge rst_n_i) begin
        if (!rst_n_i) begin
            div_q <= '0;
            cx_q  <= '0;
        end else if (hsync_i) begin
            // Line start
            div_q <= '0;
            cx_q  <= '0;
        end else begin
            div_q <= div_q + DW'(1);
            if (step) begin
                cx_q <= cx_q + CW'(1);
            end
        end
    end

    assign cx_o = cx_q;

    a_cx_in_range: assert property (@(posedge a2bus_if) disable iff (!rst_n_i)
        cx_o <= HMAX);

endmodule

`default_nettype wire

//--- logic/fb_source_select.sv
// ====================
// Framebuffer source select between the
// Apple II and VGC scanner streams
// ====================

`timescale 1ns/1ps
`default_nettype none

`include "a2_settings.svh"

module fb_source_select (
    input  logic                       a2bus_if,
    input  logic                       rst_n_i,
    input  logic                       vsync_i,
    input  logic                       shrg_i,
    input  a2_display_pkg::fb_stream_t apple_i,
    input  a2_display_pkg::fb_stream_t vgc_i,
    output a2_display_pkg::fb_stream_t fb_o,
    output a2_display_pkg::fb_geom_t   geom_o
);

    localparam a2_display_pkg::fb_geom_t APPLE_GEOM = '{
        width:  11'(`A2_APPLE_W),
        height: 10'(`A2_APPLE_H)
    };
    localparam a2_display_pkg::fb_geom_t VGC_GEOM = '{
        width:  11'(`A2_VGC_W),
        height: 10'(`A2_VGC_H)
    };

    logic                       use_vgc_q;
    a2_display_pkg::fb_stream_t fb_q;
    a2_display_pkg::fb_geom_t   geom_q;

    // Mode only follows SHRG at a frame boundary
    always_ff @(posedge a2bus_if or negedge rst_n_i) begin
        if (!rst_n_i) begin
            use_vgc_q <= 1'b0;
        end else if (vsync_i) begin
            use_vgc_q <= shrg_i;
        end
    end

    // Stream and size move together
    always_ff @(posedge a2bus_if or negedge rst_n_i) begin
        if (!rst_n_i) begin
            fb_q   <= '0;
            geom_q <= '0;
        end else if (use_vgc_q) begin
            fb_q   <= vgc_i;
            geom_q <= VGC_GEOM;
        end else begin
            fb_q   <= apple_i;
            geom_q <= APPLE_GEOM;
        end
    end

    assign fb_o   = fb_q;
    assign geom_o = geom_q;

    a_switch_on_vsync: assert property (@(posedge a2bus_if) disable iff (!rst_n_i)
        !$stable(use_vgc_q) |-> $past(vsync_i));

endmodule

`default_nettype wire

//--- logic/border_palette.sv
// ====================
// Border colour lookup, RGB444 palette
// expanded to RGB666
// ====================

`timescale 1ns/1ps
`default_nettype none

module border_palette (
    input  logic                    a2bus_if,
    input  logic                    rst_n_i,
    input  logic [3:0]              index_i,
    input  logic                    gs_i,
    output a2_display_pkg::rgb666_t color_o
);

    // Lower half Apple II colours, upper half IIgs colours
    localparam logic [11:0] PALETTE [0:31] = '{
        12'h000, 12'h924, 12'h42a, 12'hd4e,
        12'h064, 12'h888, 12'h39e, 12'hcbf,
        12'h450, 12'hc73, 12'h888, 12'hfac,
        12'h3c2, 12'hcd6, 12'h7ec, 12'hfff,
        12'h000, 12'hd03, 12'h009, 12'hd2d,
        12'h072, 12'h555, 12'h22f, 12'h6af,
        12'h850, 12'hf60, 12'haaa, 12'hf98,
        12'h1d0, 12'hff0, 12'h4f9, 12'hfff
    };

    logic [4:0]              addr;
    logic [11:0]             rgb444;
    a2_display_pkg::rgb666_t rgb666;
    a2_display_pkg::rgb666_t color_q;

    assign addr   = {gs_i, index_i};
    assign rgb444 = PALETTE[addr];

    // Each nibble lands in the top of its 6-bit field
    assign rgb666.r = {rgb444[11:8], 2'b00};
    assign rgb666.g = {rgb444[7:4], 2'b00};
    assign rgb666.b = {rgb444[3:0], 2'b00};

    always_ff @(posedge a2bus_if or negedge rst_n_i) begin
        if (!rst_n_i) begin
            color_q <= '0;
        end else begin
            color_q <= rgb666;
        end
    end

    assign color_o = color_q;

endmodule

`default_nettype wire

//--- logic/a2_video_audio_top.sv
// ====================
// Top level joining the audio mixer, VDP counter,
// framebuffer select and border palette
// ====================

`timescale 1ns/1ps
`default_nettype none

`include "a2_settings.svh"

module a2_video_audio_top #(
    parameter bit SPEAKER_ENABLE = 1'b0
) (
    input  logic                       a2bus_if,
    input  logic                       rst_n_i,

    // Audio
    input  a2_display_pkg::audio_src_t audio_src_i,
    output a2_display_pkg::stereo_t    audio_o,

    // VDP raster
    input  logic                       hsync_i,
    output logic [`A2_HCNT_W-1:0]      cx_o,

    // Framebuffer streams
    input  logic                       vsync_i,
    input  logic                       shrg_i,
    input  a2_display_pkg::fb_stream_t apple_fb_i,
    input  a2_display_pkg::fb_stream_t vgc_fb_i,
    output a2_display_pkg::fb_stream_t fb_o,
    output a2_display_pkg::fb_geom_t   geom_o,

    // Border
    input  logic [3:0]                 border_index_i,
    input  logic                       gs_i,
    output a2_display_pkg::rgb666_t    border_o
);

    audio_mixer #(
        .SPEAKER_ENABLE(SPEAKER_ENABLE)
    ) u_audio_mixer (
        .a2bus_if(a2bus_if),
        .rst_n_i (rst_n_i),
        .src_i   (audio_src_i),
        .audio_o (audio_o)
    );

    vdp_raster_counter u_vdp_raster_counter (
        .a2bus_if(a2bus_if),
        .rst_n_i (rst_n_i),
        .hsync_i (hsync_i),
        .cx_o    (cx_o)
    );

    fb_source_select u_fb_source_select (
        .a2bus_if(a2bus_if),
        .rst_n_i (rst_n_i),
        .vsync_i (vsync_i),
        .shrg_i  (shrg_i),
        .apple_i (apple_fb_i),
        .vgc_i   (vgc_fb_i),
        .fb_o    (fb_o),
        .geom_o  (geom_o)
    );

    border_palette u_border_palette (
        .a2bus_if(a2bus_if),
        .rst_n_i (rst_n_i),
        .index_i (border_index_i),
        .gs_i    (gs_i),
        .color_o (border_o)
    );

endmodule

`default_nettype wire

//--- bench/tb_a2_model.svh
// ====================
// Reference model of the card's top level,
// random number generator and compare task
// ====================

`ifndef TB_A2_MODEL_SVH
`define TB_A2_MODEL_SVH

    // Border colours as RGB444, Apple II half then IIgs half
    localparam logic [11:0] BORDER_RGB444 [0:31] = '{
        12'h000, 12'h924, 12'h42a, 12'hd4e,
        12'h064, 12'h888, 12'h39e, 12'hcbf,
        12'h450, 12'hc73, 12'h888, 12'hfac,
        12'h3c2, 12'hcd6, 12'h7ec, 12'hfff,
        12'h000, 12'hd03, 12'h009, 12'hd2d,
        12'h072, 12'h555, 12'h22f, 12'h6af,
        12'h850, 12'hf60, 12'haaa, 12'hf98,
        12'h1d0, 12'hff0, 12'h4f9, 12'hfff
    };

    logic [31:0] lcg_state = 32'hf7c7;

    // Model state and expected outputs
    a2_display_pkg::stereo_t    audio_pipe = '0;
    a2_display_pkg::stereo_t    exp_audio  = '0;
    int                         m_div      = 0;
    int                         m_cx       = 0;
    logic                       m_sel      = 1'b0;
    a2_display_pkg::fb_stream_t exp_fb     = '0;
    a2_display_pkg::fb_geom_t   exp_geom   = '0;
    a2_display_pkg::rgb666_t    exp_border = '0;
    logic                       sat_seen   = 1'b0;
    logic                       vgc_seen   = 1'b0;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Speaker weighs 4096, the 10-bit sources are scaled by 8
    function automatic logic [15:0] mix_channel(input a2_display_pkg::audio_src_t s,
                                                input logic [15:0] ens,
                                                input logic [9:0] mb);
        logic [31:0] total;
        total = 32'(ens) + 32'(s.spr) * 8 + 32'(mb) * 8;
        if (s.spk_sw) begin
            total = total + 32'(s.spk) * 4096;
        end
        return total[15:0];
    endfunction

    function automatic a2_display_pkg::rgb666_t expand_border(input logic gs_in,
                                                              input logic [3:0] idx);
        logic [11:0]             entry;
        a2_display_pkg::rgb666_t c;
        entry = BORDER_RGB444[int'(gs_in) * 16 + int'(idx)];
        c.r = 6'(entry[11:8] * 4);
        c.g = 6'(entry[7:4] * 4);
        c.b = 6'(entry[3:0] * 4);
        return c;
    endfunction

    // One active clock edge, using the inputs the DUT just sampled
    task automatic step_model();
        exp_audio = audio_pipe;
        audio_pipe.left  = mix_channel(audio_src, audio_src.ens_l, audio_src.mb_l);
        audio_pipe.right = mix_channel(audio_src, audio_src.ens_r, audio_src.mb_r);

        if (hsync) begin
            m_div = 0;
            m_cx  = 0;
        end else begin
            if (m_div == `A2_HDIV - 1 && m_cx < `A2_HMAX) begin
                m_cx = m_cx + 1;
            end
            m_div = (m_div + 1) % `A2_HDIV;
        end
        if (m_cx == `A2_HMAX) begin
            sat_seen = 1'b1;
        end

        // Output follows the mode held before this edge
        if (m_sel) begin
            exp_fb          = vgc_fb;
            exp_geom.width  = 11'(`A2_VGC_W);
            exp_geom.height = 10'(`A2_VGC_H);
            vgc_seen        = 1'b1;
        end else begin
            exp_fb          = apple_fb;
            exp_geom.width  = 11'(`A2_APPLE_W);
            exp_geom.height = 10'(`A2_APPLE_H);
        end
        if (vsync) begin
            m_sel = shrg;
        end

        exp_border = expand_border(gs, border_index);
    endtask

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            $display("FAIL at %0t ns: %s is %0h, expected %0h", $time, what, got, expected);
            $display("Test failures found");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic compare_outputs();
        check_value("audio left", $unsigned(audio.left), $unsigned(exp_audio.left));
        check_value("audio right", $unsigned(audio.right), $unsigned(exp_audio.right));
        check_value("raster counter", cx, m_cx);
        check_value("framebuffer stream", fb, exp_fb);
        check_value("frame geometry", geom, exp_geom);
        check_value("border colour", border, exp_border);
    endtask

`endif

//--- bench/tb_a2_video_audio.sv
// ====================
// Testbench top with clock, reset, random
// stimulus, timeout and output checks
// ====================

`timescale 1ns/1ps
`default_nettype none

`include "a2_settings.svh"

module tb_a2_video_audio;

    localparam int RUN_CYCLES     = 4000;
    localparam int TIMEOUT_CYCLES = RUN_CYCLES + RUN_CYCLES / 4;
    // No hsync in this window so the counter can saturate
    localparam int QUIET_FROM     = 300;
    localparam int QUIET_TO       = 3800;

    logic                       a2bus_if;
    logic                       rst_n;
    a2_display_pkg::audio_src_t audio_src;
    a2_display_pkg::stereo_t    audio;
    logic                       hsync;
    logic [`A2_HCNT_W-1:0]      cx;
    logic                       vsync;
    logic                       shrg;
    a2_display_pkg::fb_stream_t apple_fb;
    a2_display_pkg::fb_stream_t vgc_fb;
    a2_display_pkg::fb_stream_t fb;
    a2_display_pkg::fb_geom_t   geom;
    logic [3:0]                 border_index;
    logic                       gs;
    a2_display_pkg::rgb666_t    border;
    int                         cycle_cnt = 0;

    a2_video_audio_top #(
        .SPEAKER_ENABLE(1'b0)
    ) u_dut (
        .a2bus_if      (a2bus_if),
        .rst_n_i       (rst_n),
        .audio_src_i   (audio_src),
        .audio_o       (audio),
        .hsync_i       (hsync),
        .cx_o          (cx),
        .vsync_i       (vsync),
        .shrg_i        (shrg),
        .apple_fb_i    (apple_fb),
        .vgc_fb_i      (vgc_fb),
        .fb_o          (fb),
        .geom_o        (geom),
        .border_index_i(border_index),
        .gs_i          (gs),
        .border_o      (border)
    );

    `include "tb_a2_model.svh"

    initial begin
        a2bus_if = 1'b0;
        forever #5 a2bus_if = ~a2bus_if;
    end

    always @(posedge a2bus_if) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failures found");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    task automatic drive_random(input int cycle);
        logic [31:0]                r;
        a2_display_pkg::audio_src_t src;
        r = lcg_next();
        src.ens_l = r[31:16];
        r = lcg_next();
        src.ens_r = r[31:16];
        r = lcg_next();
        src.spr  = r[31:22];
        src.mb_l = r[21:12];
        r = lcg_next();
        src.mb_r   = r[31:22];
        src.spk    = r[21];
        src.spk_sw = r[20];
        audio_src <= src;

        // Roughly one line start in 64 clocks
        r = lcg_next();
        hsync <= (r[31:26] == 6'd0) && !(cycle >= QUIET_FROM && cycle < QUIET_TO);

        r = lcg_next();
        vsync <= (r[31:25] == 7'd0);
        if (r[24:19] == 6'd0) begin
            shrg <= ~shrg;
        end

        r = lcg_next();
        apple_fb <= r[31:12];
        r = lcg_next();
        vgc_fb <= r[31:12];
        r = lcg_next();
        border_index <= r[31:28];
        gs           <= r[27];
    endtask

    initial begin
        rst_n        = 1'b0;
        audio_src    = '0;
        hsync        = 1'b0;
        vsync        = 1'b0;
        shrg         = 1'b0;
        apple_fb     = '0;
        vgc_fb       = '0;
        border_index = '0;
        gs           = 1'b0;

        repeat (3) @(posedge a2bus_if);
        rst_n <= 1'b1;
        @(negedge a2bus_if);
        // Every output register starts empty
        check_value("audio after reset", audio, '0);
        check_value("raster counter after reset", cx, '0);
        check_value("stream after reset", fb, '0);
        check_value("geometry after reset", geom, '0);
        check_value("border after reset", border, '0);

        for (int cycle = 0; cycle < RUN_CYCLES; cycle++) begin
            @(posedge a2bus_if);
            step_model();
            drive_random(cycle);
            @(negedge a2bus_if);
            compare_outputs();
        end

        check_value("raster counter reached its maximum", sat_seen, 1'b1);
        check_value("VGC stream selected at least once", vgc_seen, 1'b1);
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+logic
+incdir+bench
logic/a2_display_pkg.sv
logic/audio_mixer.sv
logic/vdp_raster_counter.sv
logic/fb_source_select.sv
logic/border_palette.sv
logic/a2_video_audio_top.sv
bench/tb_a2_video_audio.sv

//--- Bender.yml
package:
  name: a2_video_audio

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/a2_display_pkg.sv
      - logic/audio_mixer.sv
      - logic/vdp_raster_counter.sv
      - logic/fb_source_select.sv
      - logic/border_palette.sv
      - logic/a2_video_audio_top.sv
  - target: test
    include_dirs:
      - logic
      - bench
    files:
      - bench/tb_a2_video_audio.sv
